// File: hw/eth_test_pkg.sv
package eth_test_pkg;

    // ------------------------------
    // stream types
    // ------------------------------

    // one byte on the MAC stream
    typedef logic [7:0] byte_t;

    // frame length in bytes from 2 to 1023
    typedef logic [9:0] frame_len_t;

    // frames per run and the good and bad counters
    typedef logic [15:0] frame_cnt_t;

    // ------------------------------
    // timing defaults
    // ------------------------------

    // idle cycles between eof and the next sof
    localparam int unsigned IFG_DEFAULT = 12;

endpackage

// File: hw/reg_map_pkg.sv
package reg_map_pkg;

    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // register addresses
    localparam reg_addr_t REG_CTRL      = 3'd0;
    localparam reg_addr_t REG_FRAME_CNT = 3'd1;
    localparam reg_addr_t REG_FRAME_LEN = 3'd2;
    localparam reg_addr_t REG_GOOD_CNT  = 3'd3;
    localparam reg_addr_t REG_BAD_CNT   = 3'd4;
    localparam reg_addr_t REG_STATUS    = 3'd5;

    // bit positions in REG_STATUS
    localparam int unsigned STAT_BUSY_BIT = 0;
    localparam int unsigned STAT_ERR_BIT  = 1;

endpackage

// File: hw/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if import eth_test_pkg::*; ();

    byte_t data;
    logic  valid;
    logic  sof;
    logic  eof;
    // fr_good is qualified by eof, fr_err may pulse anywhere in a frame
    logic  fr_good;
    logic  fr_err;

    modport source (
        output data, valid, sof, eof, fr_good, fr_err
    );

    modport sink (
        input data, valid, sof, eof, fr_good, fr_err
    );

endinterface

// File: hw/test_ctrl_if.sv
`timescale 1ns/1ps

interface test_ctrl_if import eth_test_pkg::*; ();

    // settings from the register port
    logic       start;
    frame_cnt_t frame_cnt;
    frame_len_t frame_len;

    // status from the generator and the checker
    logic       gen_busy;
    logic       chk_busy;
    frame_cnt_t good_cnt;
    frame_cnt_t bad_cnt;
    logic       any_err;

    modport ctrl (
        output start, frame_cnt, frame_len,
        input  gen_busy, chk_busy, good_cnt, bad_cnt, any_err
    );

    modport gen (
        input  start, frame_cnt, frame_len,
        output gen_busy
    );

    modport chk (
        input  start, frame_cnt, frame_len,
        output chk_busy, good_cnt, bad_cnt, any_err
    );

    modport led (
        input gen_busy, chk_busy, any_err
    );

endinterface

// File: hw/host_reg_port.sv
`timescale 1ns/1ps

module host_reg_port import eth_test_pkg::*; import reg_map_pkg::*; (
    input  logic      clk20_g,
    input  logic      rst_i,
    input  logic      req_i,
    input  logic      we_i,
    input  reg_addr_t addr_i,
    input  reg_data_t wdata_i,
    output logic      ack_o,
    output reg_data_t rdata_o,
    test_ctrl_if.ctrl ctrl
);

    typedef enum logic {HS_IDLE, HS_ACK} hs_state_e;

    hs_state_e hs_state;
    logic      req_q;
    logic      access;
    logic      busy;
    reg_data_t rd_mux;

    assign busy   = ctrl.gen_busy | ctrl.chk_busy;
    // req is taken one cycle after it was registered
    assign access = (hs_state == HS_IDLE) && req_q && req_i;
    assign ack_o  = (hs_state == HS_ACK);

    // ------------------------------
    // four-phase handshake
    // ------------------------------
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            req_q    <= 1'b0;
            hs_state <= HS_IDLE;
        end else begin
            req_q <= req_i;
            case (hs_state)
                HS_IDLE: if (access) hs_state <= HS_ACK;
                HS_ACK:  if (!req_i) hs_state <= HS_IDLE;
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    // settings and start pulse
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            ctrl.start     <= 1'b0;
            ctrl.frame_cnt <= '0;
            ctrl.frame_len <= '0;
        end else begin
            // start is dropped while a run is still going
            ctrl.start <= access && we_i && (addr_i == REG_CTRL) && wdata_i[0] && !busy;
            if (access && we_i) begin
                case (addr_i)
                    REG_FRAME_CNT: ctrl.frame_cnt <= frame_cnt_t'(wdata_i);
                    REG_FRAME_LEN: ctrl.frame_len <= frame_len_t'(wdata_i);
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------
    // read-back
    // ------------------------------
    always_comb begin
        rd_mux = '0;
        case (addr_i)
            REG_FRAME_CNT: rd_mux = ctrl.frame_cnt;
            REG_FRAME_LEN: rd_mux = reg_data_t'(ctrl.frame_len);
            REG_GOOD_CNT:  rd_mux = ctrl.good_cnt;
            REG_BAD_CNT:   rd_mux = ctrl.bad_cnt;
            REG_STATUS: begin
                rd_mux[STAT_BUSY_BIT] = busy;
                rd_mux[STAT_ERR_BIT]  = ctrl.any_err;
            end
            default: rd_mux = '0;
        endcase
    end

    // valid together with ack
    always_ff @(posedge clk20_g) begin
        if (access) begin
            rdata_o <= rd_mux;
        end
    end

endmodule

// File: hw/frame_gen.sv
`timescale 1ns/1ps

module frame_gen import eth_test_pkg::*; #(
    parameter int unsigned IFG_CYCLES = IFG_DEFAULT
) (
    input  logic          clk20_g,
    input  logic          rst_i,
    test_ctrl_if.gen      ctrl,
    byte_stream_if.source tx
);

    localparam int unsigned GAP_W = (IFG_CYCLES > 1) ? $clog2(IFG_CYCLES) : 1;
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(IFG_CYCLES - 1);

    typedef enum logic [1:0] {IDLE, SEND, GAP} gen_state_e;

    gen_state_e       state;
    frame_cnt_t       cnt_q;
    frame_cnt_t       seq;
    frame_len_t       len_q;
    frame_len_t       idx;
    logic [GAP_W-1:0] gap_cnt;
    logic             last_byte;
    logic             last_frame;

    assign last_byte  = (idx == len_q - frame_len_t'(1));
    assign last_frame = (seq == cnt_q - frame_cnt_t'(1));

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            state   <= IDLE;
            cnt_q   <= '0;
            len_q   <= '0;
            seq     <= '0;
            idx     <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // a count of zero leaves the generator idle
                    if (ctrl.start && (ctrl.frame_cnt != '0)) begin
                        cnt_q <= ctrl.frame_cnt;
                        len_q <= ctrl.frame_len;
                        seq   <= '0;
                        idx   <= '0;
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (last_byte) begin
                        idx     <= '0;
                        seq     <= seq + 1'b1;
                        gap_cnt <= '0;
                        if (last_frame) begin
                            state <= IDLE;
                        end else if (IFG_CYCLES != 0) begin
                            state <= GAP;
                        end
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_LAST) state <= SEND;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // byte k of a frame is seq + k
    assign tx.data    = seq[7:0] + idx[7:0];
    assign tx.valid   = (state == SEND);
    assign tx.sof     = (state == SEND) && (idx == '0);
    assign tx.eof     = (state == SEND) && last_byte;
    assign tx.fr_good = 1'b1;
    assign tx.fr_err  = 1'b0;

    assign ctrl.gen_busy = (state != IDLE);

endmodule

// File: hw/frame_chk.sv
`timescale 1ns/1ps

module frame_chk import eth_test_pkg::*; (
    input  logic        clk20_g,
    input  logic        rst_i,
    test_ctrl_if.chk    ctrl,
    byte_stream_if.sink rx
);

    typedef enum logic {WAIT_SOF, IN_FRAME} chk_state_e;

    chk_state_e  state;
    frame_cnt_t  cnt_q;
    frame_cnt_t  exp_seq;
    frame_cnt_t  seq_use;
    frame_cnt_t  good_nx;
    frame_cnt_t  bad_nx;
    frame_len_t  len_q;
    frame_len_t  idx;
    frame_len_t  cur_idx;
    byte_t       exp_byte;
    logic        err_q;
    logic        start_byte;
    logic        abort;
    logic        active;
    logic        hit_err;
    logic        sticky;
    logic        done_frame;
    logic [16:0] total_nx;

    // ------------------------------
    // per-byte judgement
    // ------------------------------
    always_comb begin
        start_byte = ctrl.chk_busy && rx.valid && rx.sof;
        // sof inside a frame closes the old one as bad
        abort      = start_byte && (state == IN_FRAME);
        active     = (state == IN_FRAME) || start_byte;
        seq_use    = abort ? exp_seq + 1'b1 : exp_seq;
        cur_idx    = start_byte ? '0 : idx;
        exp_byte   = seq_use[7:0] + cur_idx[7:0];

        hit_err = rx.fr_err;
        if (rx.valid && (rx.data != exp_byte)) hit_err = 1'b1;
        if (rx.valid && rx.eof) begin
            // frame good flag and length both checked on the last byte
            if (!rx.fr_good || (cur_idx != len_q - frame_len_t'(1))) hit_err = 1'b1;
        end

        sticky     = active && ((err_q && !start_byte) || hit_err);
        done_frame = active && rx.valid && rx.eof;

        good_nx  = ctrl.good_cnt + frame_cnt_t'(done_frame && !sticky);
        bad_nx   = ctrl.bad_cnt + frame_cnt_t'(done_frame && sticky) + frame_cnt_t'(abort);
        total_nx = {1'b0, good_nx} + {1'b0, bad_nx};
    end

    // ------------------------------
    // counters and run state
    // ------------------------------
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            state         <= WAIT_SOF;
            cnt_q         <= '0;
            len_q         <= '0;
            exp_seq       <= '0;
            idx           <= '0;
            err_q         <= 1'b0;
            ctrl.chk_busy <= 1'b0;
            ctrl.good_cnt <= '0;
            ctrl.bad_cnt  <= '0;
            ctrl.any_err  <= 1'b0;
        end else if (ctrl.start) begin
            state         <= WAIT_SOF;
            cnt_q         <= ctrl.frame_cnt;
            len_q         <= ctrl.frame_len;
            exp_seq       <= '0;
            idx           <= '0;
            err_q         <= 1'b0;
            ctrl.chk_busy <= (ctrl.frame_cnt != '0);
            ctrl.good_cnt <= '0;
            ctrl.bad_cnt  <= '0;
            ctrl.any_err  <= 1'b0;
        end else if (ctrl.chk_busy) begin
            ctrl.good_cnt <= good_nx;
            ctrl.bad_cnt  <= bad_nx;
            ctrl.any_err  <= ctrl.any_err | (done_frame && sticky) | abort;
            // expected sequence moves on whatever the verdict
            exp_seq <= exp_seq + frame_cnt_t'(abort) + frame_cnt_t'(done_frame);
            err_q   <= sticky && !done_frame;
            if (done_frame) begin
                idx   <= '0;
                state <= WAIT_SOF;
            end else if (active) begin
                state <= IN_FRAME;
                if (rx.valid) idx <= cur_idx + 1'b1;
            end
            if (total_nx >= {1'b0, cnt_q}) begin
                ctrl.chk_busy <= 1'b0;
                state         <= WAIT_SOF;
            end
        end
    end

endmodule

// File: hw/status_led.sv
`timescale 1ns/1ps

module status_led #(
    parameter int unsigned BLINK_HALF_CYCLES = 10_000_000
) (
    input  logic     clk20_g,
    input  logic     rst_i,
    test_ctrl_if.led ctrl,
    output logic     led_o
);

    localparam int unsigned CNT_W = (BLINK_HALF_CYCLES > 1) ? $clog2(BLINK_HALF_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLINK_HALF_CYCLES - 1);

    logic [CNT_W-1:0] blink_cnt;
    logic             blink_q;
    logic             busy;

    assign busy = ctrl.gen_busy | ctrl.chk_busy;

    // free-running half-period counter
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            blink_cnt <= '0;
            blink_q   <= 1'b0;
        end else if (blink_cnt == CNT_LAST) begin
            blink_cnt <= '0;
            blink_q   <= ~blink_q;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // on while busy, dark after an error, blink otherwise
    assign led_o = busy ? 1'b1 : (ctrl.any_err ? 1'b0 : blink_q);

endmodule

// File: hw/eth_loop_test.sv
`timescale 1ns/1ps

module eth_loop_test import eth_test_pkg::*; import reg_map_pkg::*; #(
    parameter int unsigned IFG_CYCLES        = IFG_DEFAULT,
    parameter int unsigned BLINK_HALF_CYCLES = 10_000_000
) (
    input  logic      clk20_g,
    input  logic      rst_i,

    // host register port
    input  logic      reg_req_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    output logic      reg_ack_o,
    output reg_data_t reg_rdata_o,

    // MAC transmit stream
    output byte_t     tx_data_o,
    output logic      tx_valid_o,
    output logic      tx_sof_o,
    output logic      tx_eof_o,

    // MAC receive stream
    input  byte_t     rx_data_i,
    input  logic      rx_valid_i,
    input  logic      rx_sof_i,
    input  logic      rx_eof_i,
    input  logic      rx_fr_good_i,
    input  logic      rx_fr_err_i,

    output logic      led_o
);

    test_ctrl_if   ctrl_bus ();
    byte_stream_if tx_stream ();
    byte_stream_if rx_stream ();

    // ------------------------------
    // stream ports
    // ------------------------------
    assign tx_data_o  = tx_stream.data;
    assign tx_valid_o = tx_stream.valid;
    assign tx_sof_o   = tx_stream.sof;
    assign tx_eof_o   = tx_stream.eof;

    assign rx_stream.data    = rx_data_i;
    assign rx_stream.valid   = rx_valid_i;
    assign rx_stream.sof     = rx_sof_i;
    assign rx_stream.eof     = rx_eof_i;
    assign rx_stream.fr_good = rx_fr_good_i;
    assign rx_stream.fr_err  = rx_fr_err_i;

    // ------------------------------
    // blocks
    // ------------------------------
    host_reg_port u_reg (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .req_i   (reg_req_i),
        .we_i    (reg_we_i),
        .addr_i  (reg_addr_i),
        .wdata_i (reg_wdata_i),
        .ack_o   (reg_ack_o),
        .rdata_o (reg_rdata_o),
        .ctrl    (ctrl_bus)
    );

    frame_gen #(
        .IFG_CYCLES (IFG_CYCLES)
    ) u_gen (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .ctrl    (ctrl_bus),
        .tx      (tx_stream)
    );

    frame_chk u_chk (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .ctrl    (ctrl_bus),
        .rx      (rx_stream)
    );

    status_led #(
        .BLINK_HALF_CYCLES (BLINK_HALF_CYCLES)
    ) u_led (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .ctrl    (ctrl_bus),
        .led_o   (led_o)
    );

endmodule

// File: tb/tb_eth_loop_test.sv
`timescale 1ns/1ps

module tb_eth_loop_test import eth_test_pkg::*; import reg_map_pkg::*; ();

    localparam int BLINK_HALF  = 8;
    localparam int NUM_ROWS    = 10;
    localparam int FAULT_NONE  = 0;
    localparam int FAULT_FLIP  = 1;
    localparam int FAULT_ERR   = 2;
    localparam int FAULT_GOOD  = 3;
    localparam int FAULT_TRUNC = 4;

    typedef struct packed {
        logic [15:0] cnt;
        logic [9:0]  len;
        logic [2:0]  mode;
        logic        restart;
        logic [15:0] exp_good;
        logic [15:0] exp_bad;
    } row_t;

    logic        clk20_g;
    logic        rst_i;
    logic        reg_req_i;
    logic        reg_we_i;
    reg_addr_t   reg_addr_i;
    reg_data_t   reg_wdata_i;
    logic        reg_ack_o;
    reg_data_t   reg_rdata_o;
    byte_t       tx_data_o;
    logic        tx_valid_o;
    logic        tx_sof_o;
    logic        tx_eof_o;
    byte_t       rx_data;
    logic        rx_valid;
    logic        rx_sof;
    logic        rx_eof;
    logic        rx_fr_good;
    logic        rx_fr_err;
    logic        led_o;

    // loopback delay line holding {data, valid, sof, eof, fr_good, fr_err}
    logic [12:0] pipe [0:2];
    row_t        rows [NUM_ROWS];
    int          row_fill;
    bit          table_ready;
    int          errors;
    int          rows_failed;
    int          cur_row;
    logic [31:0] lfsr_state;
    // loopback fault setup and tx position tracking
    int          cur_len;
    int          fault_mode;
    int          fault_frame;
    int          fault_byte;
    int          mon_frame;
    int          mon_byte;

    assign {rx_data, rx_valid, rx_sof, rx_eof, rx_fr_good, rx_fr_err} = pipe[2];

    eth_loop_test #(
        .BLINK_HALF_CYCLES (BLINK_HALF)
    ) u_dut (
        .clk20_g      (clk20_g),
        .rst_i        (rst_i),
        .reg_req_i    (reg_req_i),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_ack_o    (reg_ack_o),
        .reg_rdata_o  (reg_rdata_o),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o),
        .tx_sof_o     (tx_sof_o),
        .tx_eof_o     (tx_eof_o),
        .rx_data_i    (rx_data),
        .rx_valid_i   (rx_valid),
        .rx_sof_i     (rx_sof),
        .rx_eof_i     (rx_eof),
        .rx_fr_good_i (rx_fr_good),
        .rx_fr_err_i  (rx_fr_err),
        .led_o        (led_o)
    );

    initial begin
        clk20_g = 1'b0;
        forever #2 clk20_g = ~clk20_g;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    task automatic add_row(input int cnt, input int len, input int mode, input bit restart,
                           input int exp_good, input int exp_bad);
        rows[row_fill] = {16'(cnt), 10'(len), 3'(mode), restart, 16'(exp_good), 16'(exp_bad)};
        row_fill++;
    endtask

    // ------------------------------
    // four-phase host port
    // ------------------------------
    // entered and left 1 ns after a rising edge
    task automatic host_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
                               output reg_data_t rdata);
        int n;
        reg_we_i    = we;
        reg_addr_i  = addr;
        reg_wdata_i = wdata;
        reg_req_i   = 1'b1;
        n = 0;
        do begin
            @(posedge clk20_g);
            #1;
            n++;
        end while (reg_ack_o !== 1'b1 && n < 16);
        if (reg_ack_o !== 1'b1) begin
            $display("register port never raised ack for address %0d", addr);
            $display("Errors found");
            $finish;
        end else begin
            if (n != 2) report_mismatch("ack latency", n, 2);
            rdata     = reg_rdata_o;
            reg_req_i = 1'b0;
            n = 0;
            do begin
                @(posedge clk20_g);
                #1;
                n++;
            end while (reg_ack_o !== 1'b0 && n < 16);
            if (n != 1) report_mismatch("ack release", n, 1);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t wdata);
        reg_data_t unused;
        host_access(1'b1, addr, wdata, unused);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t rdata);
        host_access(1'b0, addr, '0, rdata);
    endtask

    // dark for the whole window after an error, else at least one toggle
    task automatic check_led_idle(input bit expect_dark);
        logic first;
        bit   toggled;
        bit   reported;
        first    = led_o;
        toggled  = 1'b0;
        reported = 1'b0;
        for (int n = 0; n < 2 * BLINK_HALF; n++) begin
            if (expect_dark && led_o !== 1'b0 && !reported) begin
                report_mismatch("led_o", led_o, 0);
                reported = 1'b1;
            end
            if (led_o !== first) toggled = 1'b1;
            @(posedge clk20_g);
            #1;
        end
        if (!expect_dark && !toggled) begin
            $display("led_o did not blink within %0d cycles after a clean run", 2 * BLINK_HALF);
            errors++;
        end
    endtask

    // ------------------------------
    // loopback with fault injection
    // ------------------------------
    initial begin : loopback
        byte_t d;
        byte_t exp_byte;
        logic  v;
        logic  s;
        logic  e;
        logic  g;
        logic  fe;
        for (int i = 0; i < 3; i++) pipe[i] = {8'h00, 3'b000, 1'b1, 1'b0};
        forever begin
            @(posedge clk20_g);
            #1;
            v  = (tx_valid_o === 1'b1) && !rst_i;
            d  = v ? tx_data_o : 8'h00;
            s  = v ? tx_sof_o : 1'b0;
            e  = v ? tx_eof_o : 1'b0;
            g  = 1'b1;
            fe = 1'b0;
            if (v) begin
                exp_byte = byte_t'(mon_frame + mon_byte);
                if (d !== exp_byte) report_mismatch("tx_data_o", d, exp_byte);
                if (s !== (mon_byte == 0)) report_mismatch("tx_sof_o", s, mon_byte == 0);
                if (e !== (mon_byte == cur_len - 1)) begin
                    report_mismatch("tx_eof_o", e, mon_byte == cur_len - 1);
                end
                if (mon_frame == fault_frame) begin
                    case (fault_mode)
                        FAULT_FLIP: if (mon_byte == fault_byte) d = ~d;
                        FAULT_ERR:  if (mon_byte == fault_byte) fe = 1'b1;
                        FAULT_GOOD: if (mon_byte == cur_len - 1) g = 1'b0;
                        FAULT_TRUNC: begin
                            // eof moves one byte earlier and the last byte vanishes
                            if (mon_byte == cur_len - 2) e = 1'b1;
                            if (mon_byte == cur_len - 1) begin
                                v = 1'b0;
                                s = 1'b0;
                                e = 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
                if (mon_byte == cur_len - 1) begin
                    mon_frame++;
                    mon_byte = 0;
                end else begin
                    mon_byte++;
                end
            end
            pipe[2] = pipe[1];
            pipe[1] = pipe[0];
            pipe[0] = {d, v, s, e, g, fe};
        end
    end

    // ------------------------------
    // one table row
    // ------------------------------
    task automatic run_row(input int r);
        row_t        row;
        reg_data_t   rd;
        reg_data_t   st;
        int          errs_before;
        int unsigned rnd;
        row         = rows[r];
        errs_before = errors;
        cur_row     = r;
        cur_len     = row.len;
        fault_mode  = row.mode;
        fault_frame = -1;
        fault_byte  = -1;
        mon_frame   = 0;
        mon_byte    = 0;
        if (row.mode != FAULT_NONE && row.cnt != 0) begin
            rand_bits(16, rnd);
            fault_frame = rnd % row.cnt;
            rand_bits(16, rnd);
            fault_byte = rnd % row.len;
        end

        write_reg(REG_FRAME_CNT, row.cnt);
        write_reg(REG_FRAME_LEN, reg_data_t'(row.len));
        read_reg(REG_FRAME_CNT, rd);
        if (rd !== row.cnt) report_mismatch("REG_FRAME_CNT", rd, row.cnt);
        read_reg(REG_FRAME_LEN, rd);
        if (rd !== reg_data_t'(row.len)) report_mismatch("REG_FRAME_LEN", rd, row.len);

        write_reg(REG_CTRL, 16'h0001);
        if (row.cnt != 0 && led_o !== 1'b1) report_mismatch("led_o", led_o, 1);
        // second start arrives while the run is busy
        if (row.restart) write_reg(REG_CTRL, 16'h0001);

        do begin
            read_reg(REG_STATUS, st);
        end while (st[STAT_BUSY_BIT] !== 1'b0);

        read_reg(REG_GOOD_CNT, rd);
        if (rd !== row.exp_good) report_mismatch("REG_GOOD_CNT", rd, row.exp_good);
        read_reg(REG_BAD_CNT, rd);
        if (rd !== row.exp_bad) report_mismatch("REG_BAD_CNT", rd, row.exp_bad);
        if (st[STAT_ERR_BIT] !== (row.exp_bad != 0)) begin
            report_mismatch("status err bit", st[STAT_ERR_BIT], row.exp_bad != 0);
        end
        // the generator sends exactly the programmed number of frames
        if (mon_frame != int'(row.cnt)) report_mismatch("tx frame count", mon_frame, row.cnt);
        if (tx_valid_o !== 1'b0) report_mismatch("tx_valid_o", tx_valid_o, 0);
        check_led_idle(row.exp_bad != 0);

        if (errors != errs_before) rows_failed++;
        $display("row %0d: cnt=%0d len=%0d fault=%0d restart=%0d -> %s", r, row.cnt,
                 row.len, row.mode, row.restart, (errors == errs_before) ? "pass" : "fail");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_i       = 1'b1;
        reg_req_i   = 1'b0;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        errors      = 0;
        rows_failed = 0;
        cur_row     = -1;
        cur_len     = 1;
        fault_mode  = FAULT_NONE;
        fault_frame = -1;
        fault_byte  = -1;
        mon_frame   = 0;
        mon_byte    = 0;
        lfsr_state  = 32'hb713_ee45;
        row_fill    = 0;

        // cnt, len, fault, restart, good, bad
        add_row(4, 64, FAULT_NONE, 1'b0, 4, 0);
        add_row(3, 2, FAULT_NONE, 1'b0, 3, 0);
        add_row(0, 16, FAULT_NONE, 1'b0, 0, 0);
        add_row(5, 300, FAULT_NONE, 1'b0, 5, 0);
        add_row(6, 20, FAULT_FLIP, 1'b0, 5, 1);
        add_row(4, 33, FAULT_ERR, 1'b0, 3, 1);
        add_row(5, 17, FAULT_GOOD, 1'b0, 4, 1);
        add_row(3, 40, FAULT_TRUNC, 1'b0, 2, 1);
        add_row(4, 2, FAULT_TRUNC, 1'b0, 3, 1);
        add_row(6, 50, FAULT_NONE, 1'b1, 6, 0);
        table_ready = 1'b1;

        repeat (3) @(posedge clk20_g);
        #1;
        rst_i = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("rows run: %0d, rows failed: %0d, failed checks: %0d",
                 NUM_ROWS, rows_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // limit from the table with frame bytes, gap and slack per frame
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 2000;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += int'(rows[r].cnt) * (int'(rows[r].len) + IFG_DEFAULT + 8);
        end
        repeat (limit) @(posedge clk20_g);
        $display("watchdog: row %0d did not finish within %0d cycles", cur_row, limit);
        $display("Errors found");
        $finish;
    end

endmodule

// File: eth_loop_test.f
hw/eth_test_pkg.sv
hw/reg_map_pkg.sv
hw/byte_stream_if.sv
hw/test_ctrl_if.sv
hw/host_reg_port.sv
hw/frame_gen.sv
hw/frame_chk.sv
hw/status_led.sv
hw/eth_loop_test.sv
tb/tb_eth_loop_test.sv

// File: Bender.yml
package:
  name: eth_loop_test

sources:
  - hw/eth_test_pkg.sv
  - hw/reg_map_pkg.sv
  - hw/byte_stream_if.sv
  - hw/test_ctrl_if.sv
  - hw/host_reg_port.sv
  - hw/frame_gen.sv
  - hw/frame_chk.sv
  - hw/status_led.sv
  - hw/eth_loop_test.sv
  - target: test
    files:
      - tb/tb_eth_loop_test.sv
